//--- Makefile
# Verilator flow for the fetch stage testbench
TOP := tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

# the run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- fetch_cfg.svh
//////////////////////////////
// configuration macros for the fetch stage
// boot offset, debug addresses, buffer depth, word width
//////////////////////////////

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and instruction word width
`define FETCH_XLEN 32

// low byte added to the 256-byte aligned boot address
`define FETCH_BOOT_OFFSET 8'h00

// debug module entry points
`define FETCH_DM_HALT_ADDR 32'h1A11_0800
`define FETCH_DM_EXC_ADDR 32'h1A11_0808

// number of fetched words the prefetch FIFO holds
`define FETCH_FIFO_DEPTH 2

`endif

//--- fetch_if_id_reg.sv
//////////////////////////////
// IF-ID pipeline register
// instruction, PC, error, valid and new flags
//////////////////////////////

`timescale 1ns/10ps

module fetch_if_id_reg (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_valid_i,
  input  fetch_pkg::word_t fetch_rdata_i,
  input  fetch_pkg::addr_t fetch_addr_i,
  input  logic             fetch_err_i,
  input  logic             id_in_ready_i,
  input  logic             pc_set_i,
  input  logic             instr_valid_clear_i,
  output logic             fetch_ready_o,
  output logic             instr_valid_id_o,
  output logic             instr_new_id_o,
  output fetch_pkg::word_t instr_rdata_id_o,
  output fetch_pkg::addr_t pc_id_o,
  output logic             instr_fetch_err_o
);

  logic load;
  logic valid_d;

  // ID stall holds the prefetch FIFO head
  assign fetch_ready_o = id_in_ready_i;
  assign load          = fetch_valid_i & id_in_ready_i;

  // incoming word squashed by a redirect, held until ID clears it
  assign valid_d = (load & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one-cycle marker of a freshly loaded word
      instr_new_id_o   <= load;
    end
  end

  // payload, frozen while ID stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      pc_id_o           <= '0;
      instr_fetch_err_o <= 1'b0;
    end else if (load) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      pc_id_o           <= fetch_addr_i;
      instr_fetch_err_o <= fetch_err_i;
    end
  end

  // a new word is valid in ID unless a redirect squashed it
  a_new_is_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o || $past(pc_set_i))
    else $error("new instruction in ID without valid");

endmodule

//--- fetch_if_stage.sv
//////////////////////////////
// instruction fetch stage top
// PC mux, prefetch unit and IF-ID register
//////////////////////////////

`timescale 1ns/10ps

module fetch_if_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  // redirect control
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_vec_t    irq_cause_i,
  // redirect targets
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  output logic                   csr_mtvec_init_o,
  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::word_t       instr_rdata_i,
  input  logic                   instr_bus_err_i,
  // ID stage
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::word_t       instr_rdata_id_o,
  output fetch_pkg::addr_t       pc_id_o,
  output logic                   instr_fetch_err_o,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   if_busy_o
);
  import fetch_pkg::*;

  addr_t pc_next;
  logic  fetch_valid;
  logic  fetch_ready;
  word_t fetch_rdata;
  logic  fetch_err;

  fetch_pc_mux u_pc_mux (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_cause_i      (irq_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_next_o        (pc_next),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // every pc_set_i redirects the prefetch unit
  fetch_prefetch u_prefetch (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (pc_next),
    .ready_i         (fetch_ready),
    .valid_o         (fetch_valid),
    .rdata_o         (fetch_rdata),
    .addr_o          (pc_if_o),
    .err_o           (fetch_err),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .busy_o          (if_busy_o)
  );

  fetch_if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (pc_if_o),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o)
  );

endmodule

//--- fetch_pc_mux.sv
//////////////////////////////
// next-PC multiplexer
// exception vectors and mtvec init pulse
//////////////////////////////

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_pc_mux (
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_vec_t    irq_cause_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  output fetch_pkg::addr_t       pc_next_o,
  output logic                   csr_mtvec_init_o
);
  import fetch_pkg::*;

  addr_t trap_base;
  addr_t exc_pc;

  // trap base is 256-byte aligned, mode bits of mtvec dropped
  assign trap_base = {csr_mtvec_i[`FETCH_XLEN-1:8], 8'h00};

  //////////////////////////////
  // exception target
  //////////////////////////////
  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = trap_base;
      // vectored entry, base + 4 * cause
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[`FETCH_XLEN-1:8], 1'b0, irq_cause_i, 2'b00};
      EXC_PC_DBD:     exc_pc = `FETCH_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `FETCH_DM_EXC_ADDR;
      default:        exc_pc = trap_base;
    endcase
  end

  //////////////////////////////
  // next PC
  //////////////////////////////
  always_comb begin
    case (pc_mux_i)
      PC_BOOT: pc_next_o = {boot_addr_i[`FETCH_XLEN-1:8], `FETCH_BOOT_OFFSET};
      PC_JUMP: pc_next_o = branch_target_i;
      PC_EXC:  pc_next_o = exc_pc;
      // return from trap handler
      PC_ERET: pc_next_o = csr_mepc_i;
      // return from debug mode
      PC_DRET: pc_next_o = csr_depc_i;
      default: pc_next_o = {boot_addr_i[`FETCH_XLEN-1:8], `FETCH_BOOT_OFFSET};
    endcase
  end

  // CSR file loads mtvec from the boot address on a boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  //////////////////////////////
  // checks
  //////////////////////////////
  always_comb begin
    // a redirect must name a real PC source
    if (pc_set_i) begin
      a_pc_mux_legal : assert (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET})
        else $error("illegal pc_mux_i on pc_set_i");
    end
    // boot address and mtvec init assume a 256-byte aligned region
    if (pc_set_i && (pc_mux_i == PC_BOOT)) begin
      a_boot_aligned : assert (boot_addr_i[7:0] == 8'h00)
        else $error("boot_addr_i low byte not zero");
    end
  end

endmodule

//--- fetch_pkg.sv
//////////////////////////////
// fetch stage types
// PC select enums, address and word types
//////////////////////////////

`include "fetch_cfg.svh"

package fetch_pkg;

  // instruction address and instruction word
  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [`FETCH_XLEN-1:0] word_t;

  // interrupt cause index used for vectored entry
  typedef logic [4:0] irq_vec_t;

  // source of the next PC
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target select
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

//--- fetch_prefetch.sv
//////////////////////////////
// prefetch unit
// instruction bus master, redirect discard, word FIFO
//////////////////////////////

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module fetch_prefetch #(
  parameter int unsigned FifoDepth = `FETCH_FIFO_DEPTH
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  logic             branch_i,
  input  fetch_pkg::addr_t branch_addr_i,
  input  logic             ready_i,
  output logic             valid_o,
  output fetch_pkg::word_t rdata_o,
  output fetch_pkg::addr_t addr_o,
  output logic             err_o,
  output logic             instr_req_o,
  output fetch_pkg::addr_t instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  fetch_pkg::word_t instr_rdata_i,
  input  logic             instr_bus_err_i,
  output logic             busy_o
);
  import fetch_pkg::*;

  localparam int unsigned   CntW     = $clog2(FifoDepth + 1);
  localparam int unsigned   PtrW     = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam logic [PtrW-1:0] LastPtr  = PtrW'(FifoDepth - 1);
  localparam logic [CntW:0]   DepthLim = (CntW + 1)'(FifoDepth);

  // request side
  addr_t           fetch_addr_q;
  addr_t           branch_target;
  logic            gnt;
  logic [CntW:0]   in_flight;
  // outstanding requests, and how many of them belong to a dead stream
  logic [CntW-1:0] out_cnt_q, out_cnt_d;
  logic [CntW-1:0] disc_cnt_q, disc_cnt_d;
  // response side
  addr_t           resp_addr_q;
  logic            resp_drop;
  logic            push;
  logic            pop;
  // word FIFO
  word_t           rdata_mem [FifoDepth];
  addr_t           addr_mem  [FifoDepth];
  logic [FifoDepth-1:0] err_mem;
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] fifo_cnt_q, fifo_cnt_d;

  //////////////////////////////
  // bus request
  //////////////////////////////
  // redirect target forced to a word boundary
  assign branch_target = {branch_addr_i[`FETCH_XLEN-1:2], 2'b00};

  // only ask while every answer is sure to find a FIFO slot
  assign in_flight    = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_q};
  assign instr_req_o  = req_i & (in_flight < DepthLim);
  assign instr_addr_o = fetch_addr_q;
  assign gnt          = instr_req_o & instr_gnt_i;
  assign busy_o       = (out_cnt_q != '0);

  //////////////////////////////
  // response handling
  //////////////////////////////
  // answers to pre-redirect requests are thrown away
  assign resp_drop = instr_rvalid_i & (disc_cnt_q != '0);
  // a response in the redirect cycle is stale as well
  assign push      = instr_rvalid_i & ~resp_drop & ~branch_i;

  // hide the old head while redirecting so no stale word is taken
  assign valid_o = (fifo_cnt_q != '0) & ~branch_i;
  assign pop     = valid_o & ready_i;
  assign rdata_o = rdata_mem[rd_ptr_q];
  assign addr_o  = addr_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];

  always_comb begin
    out_cnt_d = out_cnt_q;
    if (gnt && !instr_rvalid_i) begin
      out_cnt_d = out_cnt_q + 1'b1;
    end else if (!gnt && instr_rvalid_i) begin
      out_cnt_d = out_cnt_q - 1'b1;
    end
    // everything still on the bus after a redirect is dead
    if (branch_i) begin
      disc_cnt_d = out_cnt_d;
    end else if (resp_drop) begin
      disc_cnt_d = disc_cnt_q - 1'b1;
    end else begin
      disc_cnt_d = disc_cnt_q;
    end
  end

  always_comb begin
    fifo_cnt_d = fifo_cnt_q;
    if (branch_i) begin
      fifo_cnt_d = '0;
    end else if (push && !pop) begin
      fifo_cnt_d = fifo_cnt_q + 1'b1;
    end else if (!push && pop) begin
      fifo_cnt_d = fifo_cnt_q - 1'b1;
    end
  end

  //////////////////////////////
  // control state
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
      fifo_cnt_q   <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      out_cnt_q  <= out_cnt_d;
      disc_cnt_q <= disc_cnt_d;
      fifo_cnt_q <= fifo_cnt_d;
      if (branch_i) begin
        fetch_addr_q <= branch_target;
        resp_addr_q  <= branch_target;
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
      end else begin
        // next sequential word once the current one is granted
        if (gnt) begin
          fetch_addr_q <= fetch_addr_q + addr_t'(4);
        end
        // responses are in order, so the tag just counts up
        if (push) begin
          resp_addr_q <= resp_addr_q + addr_t'(4);
          wr_ptr_q    <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // FIFO storage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_mem <= '{default: '0};
      addr_mem  <= '{default: '0};
      err_mem   <= '0;
    end else if (push) begin
      rdata_mem[wr_ptr_q] <= instr_rdata_i;
      addr_mem[wr_ptr_q]  <= resp_addr_q;
      err_mem[wr_ptr_q]   <= instr_bus_err_i;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////
  a_req_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("instruction request not word aligned");

  // a waiting request stays up on the same address until granted, unless redirected
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i && !branch_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request dropped or moved before grant");

endmodule

//--- project.f
+incdir+.
fetch_pkg.sv
fetch_pc_mux.sv
fetch_prefetch.sv
fetch_if_id_reg.sv
fetch_if_stage.sv
tb_fetch.sv

//--- tb_fetch.sv
//////////////////////////////
// testbench for the fetch stage
// clock, reset, instruction memory model, watchdog
// directed tests for redirect, vectors, stalls, errors
//////////////////////////////

`timescale 1ns/10ps
`include "fetch_cfg.svh"

module tb_fetch;
  import fetch_pkg::*;

  localparam addr_t PATTERN   = 32'hA5A5_0000;
  localparam addr_t BOOT_ADDR = 32'h0000_1000;
  localparam addr_t MTVEC     = 32'h0000_4001;
  localparam addr_t TRAP_BASE = MTVEC & 32'hFFFF_FF00;
  localparam addr_t MEPC      = 32'h5000_0100;
  localparam addr_t DEPC      = 32'h6000_0200;
  localparam addr_t ERR_ADDR  = 32'h0000_2010;
  localparam int    NUM_TESTS = 6;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_i = 1'b0;
  logic pc_set_i = 1'b0;
  pc_sel_e pc_mux_i = PC_BOOT;
  exc_pc_sel_e exc_pc_mux_i = EXC_PC_EXC;
  irq_vec_t irq_cause_i = '0;
  addr_t boot_addr_i = BOOT_ADDR;
  addr_t branch_target_i = '0;
  addr_t csr_mepc_i = MEPC;
  addr_t csr_depc_i = DEPC;
  addr_t csr_mtvec_i = MTVEC;
  logic id_in_ready_i = 1'b1;
  logic instr_valid_clear_i = 1'b0;
  logic instr_gnt_i;
  logic instr_rvalid_i = 1'b0;
  word_t instr_rdata_i = '0;
  logic instr_bus_err_i = 1'b0;
  logic csr_mtvec_init_o, instr_req_o, instr_valid_id_o, instr_new_id_o;
  logic instr_fetch_err_o, if_busy_o;
  addr_t instr_addr_o, pc_id_o, pc_if_o;
  word_t instr_rdata_id_o;

  int seed = 24831;
  int checks = 0;
  int errors = 0;

  fetch_if_stage UUT (.*);

  always #50 clk_i = ~clk_i;

  //////////////////////////////
  // instruction memory model
  //////////////////////////////
  logic        xfer_q;
  logic        stall_q;
  addr_t       xfer_addr_q;
  int unsigned gnt_wait = 0;

  // grant follows the request once the random wait has run out
  assign instr_gnt_i = instr_req_o && (gnt_wait == 0);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_q      <= 1'b0;
      stall_q     <= 1'b0;
      xfer_addr_q <= '0;
    end else begin
      xfer_q      <= instr_req_o && instr_gnt_i;
      stall_q     <= instr_req_o && !instr_gnt_i;
      xfer_addr_q <= instr_addr_o;
    end
  end

  // answer one cycle after each transfer, then draw the next wait
  always @(negedge clk_i) begin
    // a granted request keeps the unit busy until its answer lands
    if (xfer_q) begin
      compare("if_busy_o", 32'(if_busy_o), 32'd1);
    end
    instr_rvalid_i  = xfer_q;
    instr_rdata_i   = xfer_addr_q ^ PATTERN;
    instr_bus_err_i = xfer_q && (xfer_addr_q == ERR_ADDR);
    if (xfer_q) begin
      gnt_wait = {$random(seed)} % 3;
    end else if (stall_q && gnt_wait != 0) begin
      gnt_wait = gnt_wait - 1;
    end
  end

  // watchdog sized at 400 cycles per test
  initial begin
    #(NUM_TESTS * 400 * 100);
    $display("ERROR: watchdog expired, the tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // waits for the next word to reach ID on a falling edge
  task automatic wait_new(output logic seen);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!instr_new_id_o && waited < 60) begin
      @(negedge clk_i);
      waited++;
    end
    seen = instr_new_id_o;
    if (!seen) begin
      errors++;
      $display("ERROR t=%0t: no new instruction reached ID", $time);
    end
  endtask

  // consumer checks each word in ID against the sequential PC stream
  task automatic expect_stream(input addr_t first_pc, input int count);
    addr_t pc;
    logic  seen;
    pc = first_pc;
    repeat (count) begin
      wait_new(seen);
      if (!seen) return;
      compare("pc_id_o", pc_id_o, pc);
      compare("instr_rdata_id_o", instr_rdata_id_o, pc ^ PATTERN);
      compare("instr_fetch_err_o", 32'(instr_fetch_err_o), 32'(pc == ERR_ADDR));
      compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd1);
      pc = pc + 32'd4;
    end
  endtask

  // one-cycle pc_set_i while ID drops its word
  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc, input irq_vec_t cause);
    @(negedge clk_i);
    pc_set_i            = 1'b1;
    pc_mux_i            = sel;
    exc_pc_mux_i        = exc;
    irq_cause_i         = cause;
    instr_valid_clear_i = 1'b1;
    #10;
    compare("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(sel == PC_BOOT));
    @(negedge clk_i);
    pc_set_i            = 1'b0;
    instr_valid_clear_i = 1'b0;
    #10;
    compare("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'd0);
    compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  // outputs held quiet while reset is asserted
  task automatic reset_values();
    compare("instr_req_o", 32'(instr_req_o), 32'd0);
    compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
    compare("instr_new_id_o", 32'(instr_new_id_o), 32'd0);
    compare("if_busy_o", 32'(if_busy_o), 32'd0);
  endtask

  task automatic boot_sequence();
    req_i = 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, '0);
    expect_stream(BOOT_ADDR + 32'(`FETCH_BOOT_OFFSET), 6);
  endtask

  // target with low bits set, fetch starts at the word boundary
  task automatic jump_redirect();
    branch_target_i = 32'h0000_3006;
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    expect_stream(32'h0000_3004, 6);
  endtask

  task automatic bus_error_tag();
    branch_target_i = ERR_ADDR - 32'd8;
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    expect_stream(ERR_ADDR - 32'd8, 5);
  endtask

  task automatic exception_vectors();
    redirect(PC_EXC, EXC_PC_EXC, '0);
    expect_stream(TRAP_BASE, 3);
    redirect(PC_EXC, EXC_PC_IRQ, 5'd5);
    expect_stream(TRAP_BASE + 32'd20, 3);
    redirect(PC_EXC, EXC_PC_DBD, '0);
    expect_stream(`FETCH_DM_HALT_ADDR, 3);
    redirect(PC_EXC, EXC_PC_DBG_EXC, '0);
    expect_stream(`FETCH_DM_EXC_ADDR, 3);
    redirect(PC_ERET, EXC_PC_EXC, '0);
    expect_stream(MEPC, 3);
    redirect(PC_DRET, EXC_PC_EXC, '0);
    expect_stream(DEPC, 3);
  endtask

  // ID stalled from the redirect on, the FIFO fills and requests stop
  task automatic back_pressure();
    addr_t held_pc;
    word_t held_data;
    id_in_ready_i   = 1'b0;
    branch_target_i = 32'h0000_7000;
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    held_pc   = pc_id_o;
    held_data = instr_rdata_id_o;
    repeat (20) begin
      @(negedge clk_i);
      compare("pc_id_o", pc_id_o, held_pc);
      compare("instr_rdata_id_o", instr_rdata_id_o, held_data);
      compare("instr_new_id_o", 32'(instr_new_id_o), 32'd0);
    end
    compare("instr_req_o", 32'(instr_req_o), 32'd0);
    // FIFO full with the first words of the new stream, nothing left on the bus
    compare("if_busy_o", 32'(if_busy_o), 32'd0);
    compare("pc_if_o", pc_if_o, 32'h0000_7000);
    id_in_ready_i = 1'b1;
    expect_stream(32'h0000_7000, 8);
  endtask

  task automatic valid_clear();
    logic seen;
    id_in_ready_i = 1'b0;
    @(negedge clk_i);
    compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd1);
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
    @(negedge clk_i);
    compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
    id_in_ready_i = 1'b1;
    wait_new(seen);
    if (seen) begin
      compare("instr_valid_id_o", 32'(instr_valid_id_o), 32'd1);
      // stream resumes right after the last word of the stall test
      compare("pc_id_o", pc_id_o, 32'h0000_7020);
    end
  endtask

  initial begin
    repeat (16) @(negedge clk_i);
    reset_values();
    rst_ni = 1'b1;
    boot_sequence();
    jump_redirect();
    bus_error_tag();
    exception_vectors();
    back_pressure();
    valid_clear();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
